// File: build.f
+incdir+tb
hdl/rvc_pkg.sv
hdl/rvc_fetch_aligner.sv
hdl/rvc_expander.sv
hdl/rvc_frontend.sv
tb/tb_rvc_frontend.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f build.f --top-module tb_rvc_frontend -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: tb/tb_rvc_model.svh
`ifndef TB_RVC_MODEL_SVH
`define TB_RVC_MODEL_SVH

// ============================================================
// random source
// ============================================================

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

// ============================================================
// base formats
// ============================================================
function automatic logic [31:0] enc_i(input logic [31:0] im, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {im[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [31:0] im, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {im[11:5], rs2, rs1, f3, im[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] im, input logic [4:0] rs1,
                                      input logic [2:0] f3);
  return {im[12], im[10:5], 5'd0, rs1, f3, im[4:1], im[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] im, input logic [4:0] rd);
  return {im[20], im[10:1], im[11], im[19:12], rd, OP_JAL};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

// ============================================================
// RVC expansion, from the field tables of the C extension
// ============================================================
function automatic logic [31:0] ref_expand(input logic [15:0] h);
  logic [31:0] im;
  logic [31:0] ci;
  logic [31:0] r;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  ra;
  logic [4:0]  rb;
  im  = '0;
  r   = '0;
  rd  = h[11:7];
  rs2 = h[6:2];
  ra  = {2'b01, h[9:7]};
  rb  = {2'b01, h[4:2]};
  ci  = {{26{h[12]}}, h[12], h[6:2]};
  case ({h[1:0], h[15:13]})
    5'b00_000: begin
      im[5:4] = h[12:11];
      im[9:6] = h[10:7];
      im[2]   = h[6];
      im[3]   = h[5];
      if (im != 0) r = enc_i(im, REG_SP, 3'b000, rb, OP_IMM);
    end
    5'b00_010, 5'b00_110: begin
      im[5:3] = h[12:10];
      im[2]   = h[6];
      im[6]   = h[5];
      if (h[15]) r = enc_s(im, rb, ra, 3'b010);
      else r = enc_i(im, ra, 3'b010, rb, OP_LOAD);
    end
    5'b01_000: r = enc_i(ci, rd, 3'b000, rd, OP_IMM);
    5'b01_001, 5'b01_101: begin
      im[11]  = h[12];
      im[4]   = h[11];
      im[9:8] = h[10:9];
      im[10]  = h[8];
      im[6]   = h[7];
      im[7]   = h[6];
      im[3:1] = h[5:3];
      im[5]   = h[2];
      im = {{20{im[11]}}, im[11:0]};
      r = enc_j(im, h[15] ? 5'd0 : REG_RA);
    end
    5'b01_010: r = enc_i(ci, 5'd0, 3'b000, rd, OP_IMM);
    5'b01_011: begin
      if (rd == REG_SP) begin
        im[9]   = h[12];
        im[4]   = h[6];
        im[6]   = h[5];
        im[8:7] = h[4:3];
        im[5]   = h[2];
        im = {{22{im[9]}}, im[9:0]};
        if (im != 0) r = enc_i(im, REG_SP, 3'b000, REG_SP, OP_IMM);
      end else if (ci != 0) begin
        r = {ci[19:0], rd, OP_LUI};
      end
    end
    5'b01_100: begin
      case (h[11:10])
        2'b00: if (!h[12]) r = enc_i({20'd0, 7'b0000000, rs2}, ra, 3'b101, ra, OP_IMM);
        2'b01: if (!h[12]) r = enc_i({20'd0, 7'b0100000, rs2}, ra, 3'b101, ra, OP_IMM);
        2'b10: r = enc_i(ci, ra, 3'b111, ra, OP_IMM);
        default: begin
          if (!h[12]) begin
            case (h[6:5])
              2'b00: r = enc_r(7'b0100000, rb, ra, 3'b000, ra);
              2'b01: r = enc_r(7'b0000000, rb, ra, 3'b100, ra);
              2'b10: r = enc_r(7'b0000000, rb, ra, 3'b110, ra);
              default: r = enc_r(7'b0000000, rb, ra, 3'b111, ra);
            endcase
          end
        end
      endcase
    end
    5'b01_110, 5'b01_111: begin
      im[8]   = h[12];
      im[4:3] = h[11:10];
      im[7:6] = h[6:5];
      im[2:1] = h[4:3];
      im[5]   = h[2];
      im = {{23{im[8]}}, im[8:0]};
      r = enc_b(im, ra, {2'b00, h[13]});
    end
    5'b10_000: if (!h[12]) r = enc_i({27'd0, rs2}, rd, 3'b001, rd, OP_IMM);
    5'b10_010: begin
      im[5]   = h[12];
      im[4:2] = h[6:4];
      im[7:6] = h[3:2];
      if (rd != 0) r = enc_i(im, REG_SP, 3'b010, rd, OP_LOAD);
    end
    5'b10_100: begin
      if (rs2 != 0) r = enc_r(7'b0000000, rs2, h[12] ? rd : 5'd0, 3'b000, rd);
      else if (rd != 0) r = enc_i(32'd0, rd, 3'b000, h[12] ? REG_RA : 5'd0, OP_JALR);
      else if (h[12]) r = enc_i(32'd1, 5'd0, 3'b000, 5'd0, OP_SYSTEM);
    end
    5'b10_110: begin
      im[5:2] = h[12:9];
      im[7:6] = h[8:7];
      r = enc_s(im, rs2, REG_SP, 3'b010);
    end
    default: r = '0;
  endcase
  return r;
endfunction

// ============================================================
// stream builder
// ============================================================

// fill words are 32-bit addi x0 forms carrying their word index
task automatic clear_image();
  for (int i = 0; i < 256; i++) begin
    mem_h[2 * i]     = 16'h0013;
    mem_h[2 * i + 1] = {4'h0, i[7:0], 4'h0};
  end
  hp = 0;
  exp_q.delete();
  exp_c.delete();
endtask

task automatic push_c(input logic [15:0] h);
  mem_h[hp] = h;
  hp++;
  exp_q.push_back(ref_expand(h));
  exp_c.push_back(1'b1);
endtask

task automatic push_w(input logic [31:0] w);
  mem_h[hp]     = w[15:0];
  mem_h[hp + 1] = w[31:16];
  hp += 2;
  exp_q.push_back(w);
  exp_c.push_back(1'b0);
endtask

// fixed bits of each kept kind, mask in the upper half and match in the lower
function automatic logic [31:0] kind_bits(input int kind);
  case (kind)
    0:  return {16'he003, 16'h0000};  // addi4spn
    1:  return {16'he003, 16'h4000};  // lw
    2:  return {16'he003, 16'hc000};  // sw
    3:  return {16'he003, 16'h0001};  // nop / addi
    4:  return {16'he003, 16'h2001};  // jal
    5:  return {16'he003, 16'h4001};  // li
    6:  return {16'hef83, 16'h6101};  // addi16sp
    7:  return {16'he803, 16'h6801};  // lui, rd of x16 and up
    8:  return {16'hfc03, 16'h8001};  // srli
    9:  return {16'hfc03, 16'h8401};  // srai
    10: return {16'hec03, 16'h8801};  // andi
    11: return {16'hfc63, 16'h8c01};  // sub
    12: return {16'hfc63, 16'h8c21};  // xor
    13: return {16'hfc63, 16'h8c41};  // or
    14: return {16'hfc63, 16'h8c61};  // and
    15: return {16'he003, 16'ha001};  // j
    16: return {16'he003, 16'hc001};  // beqz
    17: return {16'he003, 16'he001};  // bnez
    18: return {16'hf003, 16'h0002};  // slli
    19: return {16'he083, 16'h4082};  // lwsp, odd rd
    20: return {16'hf0ff, 16'h8082};  // jr, odd rs1
    21: return {16'hf043, 16'h8042};  // mv
    22: return {16'hffff, 16'h9002};  // ebreak
    23: return {16'hf0ff, 16'h9082};  // jalr, odd rs1
    24: return {16'hf043, 16'h9042};  // add
    default: return {16'he003, 16'hc002};  // swsp
  endcase
endfunction

// random encoding of one kind with a defined expansion
task automatic draw_c(input int kind, output logic [15:0] h);
  logic [31:0] r;
  logic [31:0] km;
  km = kind_bits(kind);
  h = km[15:0];
  for (int tries = 0; tries < 1000; tries++) begin
    r = rand_bits(16);
    h = (r[15:0] & ~km[31:16]) | km[15:0];
    if (ref_expand(h) != 0) break;
  end
endtask

function automatic logic [31:0] draw_w();
  logic [31:0] r;
  r = rand_bits(30);
  return {r[29:0], 2'b11};
endfunction

`endif

// File: tb/tb_rvc_frontend.sv
`default_nettype none

module tb_rvc_frontend import rvc_pkg::*; ();

  logic        clk;
  logic        reset;
  logic [31:0] fetch_word;
  logic        fetch_advance;
  logic        redirect;
  logic [31:0] redirect_addr;
  logic [31:0] instruction_out;
  logic        compressed;
  logic        fetch_hold;

  logic [31:0] lfsr_state = 32'hf868;
  logic [15:0] mem_h [0:511];
  int          hp;
  logic [31:0] exp_q [$];
  logic        exp_c [$];
  logic [31:0] ptr;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          hold_count;
  bit          hold_forbidden;
  bit          stall_check;
  logic [31:0] held_out;
  logic        held_c;
  logic        held_h;

  `include "tb_rvc_model.svh"

  rvc_frontend UUT (
    .clk             (clk),
    .reset           (reset),
    .fetch_word      (fetch_word),
    .fetch_advance   (fetch_advance),
    .redirect        (redirect),
    .redirect_addr   (redirect_addr),
    .instruction_out (instruction_out),
    .compressed      (compressed),
    .fetch_hold      (fetch_hold)
  );

  always #4 clk = ~clk;

  // ============================================================
  // fetch unit model
  // ============================================================
  assign fetch_word = {mem_h[{ptr[9:2], 1'b1}], mem_h[{ptr[9:2], 1'b0}]};

  always @(posedge clk or negedge reset) begin
    if (!reset) begin
      ptr <= '0;
    end else if (redirect) begin
      ptr <= {redirect_addr[31:2], 2'b00};
    end else if (fetch_advance && !fetch_hold) begin
      ptr <= ptr + 32'd4;
    end
  end

  // ============================================================
  // checks
  // ============================================================
  always @(posedge clk) begin
    if (reset && fetch_advance && instruction_out != 0 && exp_q.size() > 0) begin
      assert (instruction_out == exp_q[0]) else begin
        $display("[FAIL] %0t instruction_out expected %h got %h",
                 $time, exp_q[0], instruction_out);
        errors++;
      end
      assert (compressed == exp_c[0]) else begin
        $display("[FAIL] %0t compressed expected %b got %b", $time, exp_c[0], compressed);
        errors++;
      end
      void'(exp_q.pop_front());
      void'(exp_c.pop_front());
    end
    if (reset && hold_forbidden && exp_q.size() > 0) begin
      assert (!fetch_hold) else begin
        $display("[FAIL] %0t fetch_hold expected 0 got 1", $time);
        errors++;
      end
    end
    if (reset && stall_check && !fetch_advance) begin
      assert (instruction_out == held_out) else begin
        $display("[FAIL] %0t instruction_out expected %h got %h while stalled",
                 $time, held_out, instruction_out);
        errors++;
      end
      assert (compressed == held_c) else begin
        $display("[FAIL] %0t compressed expected %b got %b while stalled",
                 $time, held_c, compressed);
        errors++;
      end
      assert (fetch_hold == held_h) else begin
        $display("[FAIL] %0t fetch_hold expected %b got %b while stalled",
                 $time, held_h, fetch_hold);
        errors++;
      end
    end
    if (reset && fetch_advance && fetch_hold && exp_q.size() > 0) begin
      hold_count++;
    end
  end

  // restart at start through a redirect, then drain the expected queue
  task automatic run_stream(input logic [31:0] start, input bit stall_en);
    int cycles;
    int k;
    @(negedge clk);
    redirect      = 1'b1;
    redirect_addr = start;
    fetch_advance = 1'b0;
    @(negedge clk);
    redirect      = 1'b0;
    fetch_advance = 1'b1;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < 4000) begin
      if (stall_en && rand_bits(2) == 0) begin
        k = 1 + rand_bits(2);
        fetch_advance = 1'b0;
        #1;
        held_out    = instruction_out;
        held_c      = compressed;
        held_h      = fetch_hold;
        stall_check = 1'b1;
        repeat (k) @(negedge clk);
        stall_check   = 1'b0;
        fetch_advance = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout: %0d expected instructions never issued", exp_q.size());
      $display("Test failed");
      $finish;
    end
    fetch_advance = 1'b0;
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: FAIL", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    int e;
    logic [15:0] h;
    logic [15:0] ha;
    logic [15:0] hb;
    logic [31:0] w;
    clk = 0;
    reset = 0;
    fetch_advance = 0;
    redirect = 0;
    redirect_addr = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    hold_forbidden = 0;
    stall_check = 0;
    held_out = '0;
    held_c = 0;
    held_h = 0;
    clear_image();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1;

    // only 32-bit words
    e = errors;
    clear_image();
    for (int i = 0; i < 20; i++) push_w(draw_w());
    hold_forbidden = 1;
    run_stream(32'd0, 0);
    hold_forbidden = 0;
    report("plain 32-bit stream", e);

    // every kind in turn, each padded by a 32-bit word
    e = errors;
    clear_image();
    for (int i = 0; i < 60; i++) begin
      draw_c(i % 26, h);
      push_c(h);
      push_w(draw_w());
    end
    run_stream(32'd0, 0);
    report("random compressed", e);

    // c.addi then add x10,x10,x11 across the word boundary
    e = errors;
    clear_image();
    push_c(16'h0505);
    push_w(32'h00b50533);
    push_w(32'h00000513);
    run_stream(32'd0, 0);
    report("straddling 32-bit", e);

    // third compressed lands in LOW_BUF
    e = errors;
    clear_image();
    push_c(16'h4501);
    push_c(16'h0505);
    push_c(16'h8082);
    push_w(32'h00c58593);
    push_w(32'h00100093);
    hold_count = 0;
    run_stream(32'd0, 0);
    assert (hold_count == 1) else begin
      $display("fetch_hold was high for %0d cycles instead of one", hold_count);
      errors++;
    end
    report("two compressed in one word", e);

    // redirects to upper and lower halves
    e = errors;
    ha = 16'h4505;
    hb = 16'h0585;
    clear_image();
    push_c(ha);
    push_c(hb);
    push_w(32'h00a58633);
    void'(exp_q.pop_front());
    void'(exp_c.pop_front());
    run_stream(32'd2, 0);
    clear_image();
    push_c(ha);
    push_w(32'h40b50533);
    push_c(hb);
    push_w(32'h00000013 | 32'h00100000);
    void'(exp_q.pop_front());
    void'(exp_c.pop_front());
    run_stream(32'd2, 0);
    clear_image();
    push_c(ha);
    push_w(32'h00b56533);
    run_stream(32'd0, 0);
    report("redirect targets", e);

    // mixed stream with back-pressure
    e = errors;
    clear_image();
    for (int i = 0; i < 80; i++) begin
      if (rand_bits(1)) begin
        draw_c(rand_bits(5) % 26, h);
        push_c(h);
      end else begin
        w = draw_w();
        push_w(w);
      end
    end
    run_stream(32'd0, 1);
    report("back-pressure", e);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/rvc_frontend.sv
`default_nettype none

module rvc_frontend import rvc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  inst_t fetch_word,
  input  logic  fetch_advance,
  input  logic  redirect,
  input  addr_t redirect_addr,
  output inst_t instruction_out,
  output logic  compressed,
  output logic  fetch_hold
);

  half_t slot_half;
  inst_t slot_word;
  logic  slot_compressed;
  inst_t expanded;

  rvc_fetch_aligner u_aligner (
    .clk             (clk),
    .reset           (reset),
    .fetch_word      (fetch_word),
    .fetch_advance   (fetch_advance),
    .redirect        (redirect),
    .redirect_addr   (redirect_addr),
    .slot_half       (slot_half),
    .slot_word       (slot_word),
    .slot_compressed (slot_compressed),
    .fetch_hold      (fetch_hold)
  );

  rvc_expander u_expander (
    .half     (slot_half),
    .expanded (expanded)
  );

  // same-cycle path from fetch word to issue
  assign compressed      = slot_compressed;
  assign instruction_out = slot_compressed ? expanded : slot_word;

endmodule

`default_nettype wire

// File: hdl/rvc_expander.sv
`default_nettype none

module rvc_expander import rvc_pkg::*; (
  input  half_t half,
  output inst_t expanded
);

  // ============================================================
  // field extraction
  // ============================================================
  logic [1:0]  quad;
  logic [2:0]  funct3;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rp_high;
  logic [4:0]  rp_low;
  logic [5:0]  imm6;
  logic [9:0]  ciw_imm;
  logic [6:0]  mem_imm;
  logic [11:0] jump_imm;
  logic [9:0]  sp16_imm;
  logic [8:0]  branch_imm;
  logic [7:0]  lwsp_imm;
  logic [7:0]  swsp_imm;

  assign quad     = half[1:0];
  assign funct3   = half[15:13];
  assign rd_full  = half[11:7];
  assign rs2_full = half[6:2];
  // rs1'/rd' at 9:7, rd'/rs2' at 4:2
  assign rp_high  = {2'b00, half[9:7]} + RVC_REG_BASE;
  assign rp_low   = {2'b00, half[4:2]} + RVC_REG_BASE;

  // immediates, all in byte units
  assign imm6       = {half[12], half[6:2]};
  assign ciw_imm    = {half[10:7], half[12:11], half[5], half[6], 2'b00};
  assign mem_imm    = {half[5], half[12:10], half[6], 2'b00};
  assign jump_imm   = {half[12], half[8], half[10:9], half[6], half[7], half[2],
                       half[11], half[5:3], 1'b0};
  assign sp16_imm   = {half[12], half[4:3], half[5], half[2], half[6], 4'b0000};
  assign branch_imm = {half[12], half[6:5], half[2], half[11:10], half[4:3], 1'b0};
  assign lwsp_imm   = {half[3:2], half[12], half[6:4], 2'b00};
  assign swsp_imm   = {half[8:7], half[12:9], 2'b00};

  // ============================================================
  // expansion
  // ============================================================
  always_comb begin
    inst_t result;
    result = '0;
    case (quad)
      2'b00: begin
        case (funct3)
          3'b000: begin
            // addi4spn, zero immediate is reserved
            if (ciw_imm != '0) begin
              result = {2'b00, ciw_imm, REG_SP, 3'b000, rp_low, OP_IMM};
            end
          end
          3'b010: result = {5'b0, mem_imm, rp_high, 3'b010, rp_low, OP_LOAD};
          3'b110: result = {5'b0, mem_imm[6:5], rp_low, rp_high, 3'b010,
                            mem_imm[4:0], OP_STORE};
          default: result = '0;
        endcase
      end
      2'b01: begin
        case (funct3)
          // addi, rd of zero gives the nop
          3'b000: result = {{6{imm6[5]}}, imm6, rd_full, 3'b000, rd_full, OP_IMM};
          3'b001: result = {jump_imm[11], jump_imm[10:1], jump_imm[11],
                            {8{jump_imm[11]}}, REG_RA, OP_JAL};
          3'b010: result = {{6{imm6[5]}}, imm6, 5'd0, 3'b000, rd_full, OP_IMM};
          3'b011: begin
            if (rd_full == REG_SP) begin
              if (sp16_imm != '0) begin
                result = {{2{sp16_imm[9]}}, sp16_imm, REG_SP, 3'b000, REG_SP, OP_IMM};
              end
            end else if (imm6 != '0) begin
              result = {{14{imm6[5]}}, imm6, rd_full, OP_LUI};
            end
          end
          3'b100: begin
            case (half[11:10])
              2'b00: begin
                if (!half[12]) begin
                  result = {7'b0000000, imm6[4:0], rp_high, 3'b101, rp_high, OP_IMM};
                end
              end
              2'b01: begin
                if (!half[12]) begin
                  result = {7'b0100000, imm6[4:0], rp_high, 3'b101, rp_high, OP_IMM};
                end
              end
              2'b10: result = {{6{imm6[5]}}, imm6, rp_high, 3'b111, rp_high, OP_IMM};
              default: begin
                // register-register ops, bit 12 set is rv64 only
                if (!half[12]) begin
                  case (half[6:5])
                    2'b00: result = {7'b0100000, rp_low, rp_high, 3'b000, rp_high, OP_REG};
                    2'b01: result = {7'b0000000, rp_low, rp_high, 3'b100, rp_high, OP_REG};
                    2'b10: result = {7'b0000000, rp_low, rp_high, 3'b110, rp_high, OP_REG};
                    default: result = {7'b0000000, rp_low, rp_high, 3'b111, rp_high, OP_REG};
                  endcase
                end
              end
            endcase
          end
          3'b101: result = {jump_imm[11], jump_imm[10:1], jump_imm[11],
                            {8{jump_imm[11]}}, 5'd0, OP_JAL};
          3'b110: result = {{3{branch_imm[8]}}, branch_imm[8:5], 5'd0, rp_high, 3'b000,
                            branch_imm[4:1], branch_imm[8], OP_BRANCH};
          default: result = {{3{branch_imm[8]}}, branch_imm[8:5], 5'd0, rp_high, 3'b001,
                             branch_imm[4:1], branch_imm[8], OP_BRANCH};
        endcase
      end
      2'b10: begin
        case (funct3)
          3'b000: begin
            if (!half[12]) begin
              result = {7'b0000000, imm6[4:0], rd_full, 3'b001, rd_full, OP_IMM};
            end
          end
          3'b010: begin
            // lwsp into x0 is reserved
            if (rd_full != '0) begin
              result = {4'b0000, lwsp_imm, REG_SP, 3'b010, rd_full, OP_LOAD};
            end
          end
          3'b100: begin
            if (!half[12]) begin
              if (rs2_full != '0) begin
                result = {7'b0000000, rs2_full, 5'd0, 3'b000, rd_full, OP_REG};
              end else if (rd_full != '0) begin
                result = {12'd0, rd_full, 3'b000, 5'd0, OP_JALR};
              end
            end else begin
              if (rs2_full != '0) begin
                result = {7'b0000000, rs2_full, rd_full, 3'b000, rd_full, OP_REG};
              end else if (rd_full != '0) begin
                result = {12'd0, rd_full, 3'b000, REG_RA, OP_JALR};
              end else begin
                result = {12'd1, 5'd0, 3'b000, 5'd0, OP_SYSTEM};
              end
            end
          end
          3'b110: result = {4'b0000, swsp_imm[7:5], rs2_full, REG_SP, 3'b010,
                            swsp_imm[4:0], OP_STORE};
          default: result = '0;
        endcase
      end
      default: result = '0;
    endcase

    // every branch must yield a 32-bit encoding or the zero word
    if (!$isunknown(half)) begin
      expand_legal: assert (quad == 2'b11 || result[1:0] == 2'b11 || result == '0);
    end
    expanded = result;
  end

endmodule

`default_nettype wire

// File: hdl/rvc_fetch_aligner.sv
`default_nettype none

module rvc_fetch_aligner import rvc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  inst_t fetch_word,
  input  logic  fetch_advance,
  input  logic  redirect,
  input  addr_t redirect_addr,
  output half_t slot_half,
  output inst_t slot_word,
  output logic  slot_compressed,
  output logic  fetch_hold
);

  align_state_t state;
  align_state_t cur_state;
  align_state_t next_state;
  inst_t        inst_buf;
  logic         buf_load;
  logic         redirect_q;
  logic         redirect_upper_q;

  // ============================================================
  // redirect capture
  // ============================================================

  // pending until a slot is consumed, the fetch word is then the target
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      redirect_q       <= 1'b0;
      redirect_upper_q <= 1'b0;
    end else if (redirect) begin
      redirect_q       <= 1'b1;
      redirect_upper_q <= redirect_addr[1];
    end else if (fetch_advance) begin
      redirect_q <= 1'b0;
    end
  end

  // the target word bypasses whatever the old path left in the state
  always_comb begin
    if (redirect_q) begin
      cur_state = redirect_upper_q ? TARGET_UPPER : ALIGNED;
    end else begin
      cur_state = state;
    end
  end

  // ============================================================
  // slot selection
  // ============================================================
  always_comb begin
    case (cur_state)
      ALIGNED: begin
        slot_half = fetch_word[15:0];
        slot_word = fetch_word;
      end
      UPPER_BUF: begin
        slot_half = inst_buf[31:16];
        // straddling instruction, low part sits in the buffer
        slot_word = {fetch_word[15:0], inst_buf[31:16]};
      end
      LOW_BUF: begin
        slot_half = inst_buf[15:0];
        slot_word = inst_buf;
      end
      default: begin
        slot_half = fetch_word[31:16];
        // upper half starts a 32-bit instruction, issue a bubble
        slot_word = '0;
      end
    endcase
  end

  assign slot_compressed = (slot_half[1:0] != 2'b11);

  // ============================================================
  // next state, buffer load and fetch hold
  // ============================================================
  always_comb begin
    next_state = cur_state;
    buf_load   = 1'b0;
    fetch_hold = 1'b0;
    case (cur_state)
      ALIGNED: begin
        if (slot_compressed) begin
          buf_load   = 1'b1;
          next_state = UPPER_BUF;
        end
      end
      UPPER_BUF: begin
        buf_load = 1'b1;
        if (slot_compressed) begin
          next_state = LOW_BUF;
        end
      end
      LOW_BUF: begin
        if (slot_compressed) begin
          // upper half of the buffer still to go
          fetch_hold = 1'b1;
          next_state = UPPER_BUF;
        end else begin
          buf_load = 1'b1;
        end
      end
      default: begin
        if (slot_compressed) begin
          next_state = ALIGNED;
        end else begin
          buf_load   = 1'b1;
          next_state = UPPER_BUF;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= ALIGNED;
    end else if (fetch_advance) begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      inst_buf <= '0;
    end else if (fetch_advance && buf_load) begin
      inst_buf <= fetch_word;
    end
  end

  // ============================================================
  // checks
  // ============================================================
  hold_after_redirect: assert property (@(posedge clk) disable iff (!reset)
    redirect |=> !fetch_hold);

  state_legal: assert property (@(posedge clk) disable iff (!reset)
    !$isunknown(state) && (state inside {ALIGNED, UPPER_BUF, LOW_BUF, TARGET_UPPER}));

endmodule

`default_nettype wire

// File: hdl/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

  // ============================================================
  // widths with a meaning
  // ============================================================

  // base instruction, also one fetch word
  typedef logic [31:0] inst_t;
  // compressed instruction or any halfword
  typedef logic [15:0] half_t;
  // byte address
  typedef logic [31:0] addr_t;

  // which halfword is the current slot
  typedef enum logic [1:0] {
    ALIGNED,
    UPPER_BUF,
    LOW_BUF,
    TARGET_UPPER
  } align_state_t;

  // ============================================================
  // base opcodes
  // ============================================================
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // fixed registers of the compressed forms
  localparam logic [4:0] REG_RA       = 5'd1;
  localparam logic [4:0] REG_SP       = 5'd2;
  // 3-bit register fields start at x8
  localparam logic [4:0] RVC_REG_BASE = 5'd8;

endpackage

`default_nettype wire
